// File: common/ag_defines.svh
`ifndef AG_DEFINES_SVH
`define AG_DEFINES_SVH

// Interrupt descriptor table
`define AG_IDTR_BASE    32'h0000_1000
`define AG_IDT_SHIFT    3

// Fixed limits, indexed by segment register number
`define AG_SEG_LIMIT_0  32'h0000_FFFF
`define AG_SEG_LIMIT_1  32'h000F_FFFF
`define AG_SEG_LIMIT_2  32'h0000_7FFF
`define AG_SEG_LIMIT_3  32'h0003_FFFF
`define AG_SEG_LIMIT_4  32'h0000_0FFF
`define AG_SEG_LIMIT_5  32'h00FF_FFFF
`define AG_SEG_LIMIT_6  32'h0000_3FFF
`define AG_SEG_LIMIT_7  32'hFFFF_FFFF

// Bytes per stack slot
`define AG_PUSH_WORD    2
`define AG_PUSH_DWORD   4

// Memory address source codes
`define AG_SEL_EA       2'd0
`define AG_SEL_STACK    2'd1
`define AG_SEL_IDT      2'd2

`define AG_SIZE_DWORD   2'd2

`endif

// File: common/ag_pkg.sv
`default_nettype none

package ag_pkg;

   typedef logic [2:0]  gpr_idx_t;
   typedef logic [2:0]  seg_idx_t;
   typedef logic [31:0] addr_t;
   typedef logic [15:0] seg_sel_t;
   typedef logic [1:0]  data_size_t;
   typedef logic [1:0]  mem_addr_sel_t;

   // Decoded instruction as presented by the decode stage
   typedef struct packed {
      addr_t         eip;
      seg_sel_t      cs;
      addr_t         imm32;
      addr_t         disp32;
      gpr_idx_t      sr1;
      gpr_idx_t      sr2;
      gpr_idx_t      sr3;
      gpr_idx_t      sib_i;
      seg_idx_t      seg1;
      seg_idx_t      seg2;
      data_size_t    data_size;
      logic          disp_en;
      logic          base_en;
      logic          sib_en;
      logic [1:0]    sib_scale;
      logic          use_cs_seg;
      logic          sp_push;
      logic          cmpxchg;
      logic [3:0]    exc_code;
      logic          jmp_rel;
      logic          jmp_abs;
      mem_addr_sel_t rd_sel;
      mem_addr_sel_t wr_sel;
      logic          mem_rd;
      logic          mem_wr;
      logic          sr1_needed;
      logic          sr2_needed;
      logic          seg1_needed;
      logic          seg2_needed;
      gpr_idx_t      dest_gpr;
      logic          ld_gpr;
      logic          ld_seg;
   } ag_in_t;

   // Register file read data for the sources above
   typedef struct packed {
      addr_t    sr1_data;
      addr_t    sr2_data;
      addr_t    sr3_data;
      addr_t    sib_i_data;
      seg_sel_t seg1_data;
      seg_sel_t seg2_data;
   } ag_rf_t;

   typedef struct packed {
      gpr_idx_t gpr;
      seg_idx_t seg;
      logic     ld_gpr;
      logic     ld_seg;
   } ag_dest_t;

   typedef struct packed {
      addr_t    neip;
      seg_sel_t ncs;
      addr_t    mem_rd_addr;
      addr_t    mem_wr_addr;
      addr_t    sp_xchg_data;
      logic     mem_rd;
      logic     mem_wr;
      ag_dest_t dest;
      logic     seg_limit_exc;
   } ag_out_t;

endpackage

`default_nettype wire

// File: addr_calc/ag_addr_calc.sv
`timescale 1ns/1ps
`default_nettype none

`include "ag_defines.svh"

module ag_addr_calc (
   input  wire ag_pkg::ag_in_t in_data,
   input  wire ag_pkg::ag_rf_t rf_data,
   output ag_pkg::addr_t       mem_rd_addr,
   output ag_pkg::addr_t       mem_wr_addr,
   output ag_pkg::addr_t       sp_xchg_data,
   output ag_pkg::addr_t       lim_offset
);

   ag_pkg::addr_t    disp_term;
   ag_pkg::addr_t    base_term;
   ag_pkg::addr_t    index_term;
   ag_pkg::seg_sel_t ea_seg;
   ag_pkg::addr_t    ea_addr;
   ag_pkg::addr_t    push_size;
   ag_pkg::addr_t    sp_adj;
   ag_pkg::addr_t    stack_addr;
   ag_pkg::addr_t    idt_addr;

   // Effective address: disp + base + scaled index, then segment base
   assign disp_term  = in_data.disp_en ? in_data.disp32 : '0;
   assign base_term  = in_data.base_en ? rf_data.sr1_data : '0;
   assign index_term = in_data.sib_en ? (rf_data.sib_i_data << in_data.sib_scale) : '0;

   assign lim_offset = disp_term + base_term + index_term;
   assign ea_seg     = in_data.use_cs_seg ? in_data.cs : rf_data.seg1_data;
   assign ea_addr    = lim_offset + {ea_seg, 16'h0000};

   // Stack slot below the current top for a push
   assign push_size  = (in_data.data_size == `AG_SIZE_DWORD) ? 32'(`AG_PUSH_DWORD)
                                                              : 32'(`AG_PUSH_WORD);
   assign sp_adj     = in_data.sp_push ? (rf_data.sr2_data - push_size) : rf_data.sr2_data;
   assign stack_addr = sp_adj + {rf_data.seg2_data, 16'h0000};

   // 8-byte gate descriptors
   assign idt_addr   = `AG_IDTR_BASE + (ag_pkg::addr_t'(in_data.exc_code) << `AG_IDT_SHIFT);

   always_comb begin
      case (in_data.rd_sel)
         `AG_SEL_STACK: mem_rd_addr = stack_addr;
         `AG_SEL_IDT:   mem_rd_addr = idt_addr;
         default:       mem_rd_addr = ea_addr;
      endcase
   end

   always_comb begin
      if (in_data.wr_sel == `AG_SEL_STACK) begin
         mem_wr_addr = stack_addr;
      end else begin
         mem_wr_addr = ea_addr;
      end
   end

   // cmpxchg carries the comparand through instead of the new SP
   assign sp_xchg_data = in_data.cmpxchg ? rf_data.sr3_data : sp_adj;

endmodule

`default_nettype wire

// File: src/ag_next_ip.sv
`timescale 1ns/1ps
`default_nettype none

module ag_next_ip (
   input  wire ag_pkg::ag_in_t in_data,
   output ag_pkg::addr_t       neip,
   output ag_pkg::seg_sel_t    ncs
);

   ag_pkg::addr_t rel_term;
   ag_pkg::addr_t rel_eip;

   // Relative target, or plain eip when sequential
   assign rel_term = in_data.jmp_rel ? in_data.disp32 : '0;
   assign rel_eip  = in_data.eip + rel_term;

   // Far jump takes offset from imm32 and selector from disp32
   assign neip = in_data.jmp_abs ? in_data.imm32 : rel_eip;
   assign ncs  = in_data.jmp_abs ? in_data.disp32[15:0] : in_data.cs;

endmodule

`default_nettype wire

// File: src/segment_limit_check.sv
`timescale 1ns/1ps
`default_nettype none

`include "ag_defines.svh"

module segment_limit_check (
   input  wire                  in_v,
   input  wire ag_pkg::ag_in_t in_data,
   input  wire ag_pkg::addr_t  lim_offset,
   output logic                seg_limit_exc
);

   ag_pkg::addr_t seg_limit;
   logic [32:0]   last_byte;
   logic [2:0]    access_size;
   logic          ea_access;

   always_comb begin
      case (in_data.seg1)
         3'd0:    seg_limit = `AG_SEG_LIMIT_0;
         3'd1:    seg_limit = `AG_SEG_LIMIT_1;
         3'd2:    seg_limit = `AG_SEG_LIMIT_2;
         3'd3:    seg_limit = `AG_SEG_LIMIT_3;
         3'd4:    seg_limit = `AG_SEG_LIMIT_4;
         3'd5:    seg_limit = `AG_SEG_LIMIT_5;
         3'd6:    seg_limit = `AG_SEG_LIMIT_6;
         default: seg_limit = `AG_SEG_LIMIT_7;
      endcase
   end

   // Byte, word, dword; the spare code counts as dword
   assign access_size = (in_data.data_size == 2'd0) ? 3'd1 :
                        (in_data.data_size == 2'd1) ? 3'd2 : 3'd4;

   // Only accesses through the effective address are checked
   assign ea_access = (in_data.mem_rd && (in_data.rd_sel == `AG_SEL_EA)) ||
                      (in_data.mem_wr && (in_data.wr_sel == `AG_SEL_EA));

   // One extra bit so an access wrapping past 4 GB still faults
   assign last_byte = {1'b0, lim_offset} + 33'(access_size) - 33'd1;

   assign seg_limit_exc = in_v && ea_access && (last_byte > {1'b0, seg_limit});

endmodule

`default_nettype wire

// File: src/reg_dependency_check.sv
`timescale 1ns/1ps
`default_nettype none

module reg_dependency_check (
   input  wire                    in_v,
   input  wire ag_pkg::ag_in_t   in_data,
   input  wire ag_pkg::ag_dest_t ag_dest,
   input  wire ag_pkg::ag_dest_t ex_dest,
   input  wire ag_pkg::ag_dest_t me_dest,
   output logic                  dep_stall
);

   ag_pkg::ag_dest_t dests [0:2];
   logic             hazard;

   function automatic logic gpr_hit(input ag_pkg::gpr_idx_t src,
                                    input ag_pkg::ag_dest_t d);
      return d.ld_gpr && (d.gpr == src);
   endfunction

   function automatic logic seg_hit(input ag_pkg::seg_idx_t src,
                                    input ag_pkg::ag_dest_t d);
      return d.ld_seg && (d.seg == src);
   endfunction

   assign dests[0] = ag_dest;
   assign dests[1] = ex_dest;
   assign dests[2] = me_dest;

   always_comb begin
      hazard = 1'b0;
      for (int i = 0; i < 3; i++) begin
         if (in_data.sr1_needed && gpr_hit(in_data.sr1, dests[i])) begin
            hazard = 1'b1;
         end
         if (in_data.sr2_needed && gpr_hit(in_data.sr2, dests[i])) begin
            hazard = 1'b1;
         end
         // Index register only read for SIB forms
         if (in_data.sib_en && gpr_hit(in_data.sib_i, dests[i])) begin
            hazard = 1'b1;
         end
         if (in_data.cmpxchg && gpr_hit(in_data.sr3, dests[i])) begin
            hazard = 1'b1;
         end
         if (in_data.seg1_needed && seg_hit(in_data.seg1, dests[i])) begin
            hazard = 1'b1;
         end
         if (in_data.seg2_needed && seg_hit(in_data.seg2, dests[i])) begin
            hazard = 1'b1;
         end
      end
   end

   assign dep_stall = in_v & hazard;

endmodule

`default_nettype wire

// File: src/ag_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "ag_defines.svh"

module ag_control (
   input  wire                 clk,
   input  wire                 rst_n,
   input  wire                 in_v,
   input  wire                 me_stall,
   input  wire                 dep_stall,
   input  wire ag_pkg::addr_t     mem_rd_addr,
   input  wire ag_pkg::addr_t     mem_wr_addr,
   input  wire ag_pkg::addr_t     sp_xchg_data,
   input  wire ag_pkg::addr_t     neip,
   input  wire ag_pkg::seg_sel_t  ncs,
   input  wire                 seg_limit_exc,
   input  wire ag_pkg::ag_in_t    in_data,
   output logic                out_v,
   output ag_pkg::ag_out_t     out_data,
   output ag_pkg::ag_dest_t    ag_dest,
   output logic                stall
);

   ag_pkg::ag_out_t next_out;
   logic            accept;

   assign stall  = dep_stall | me_stall;
   assign accept = in_v & ~stall;

   always_comb begin
      next_out               = '0;
      next_out.neip          = neip;
      next_out.ncs           = ncs;
      next_out.mem_rd_addr   = mem_rd_addr;
      next_out.mem_wr_addr   = mem_wr_addr;
      next_out.sp_xchg_data  = sp_xchg_data;
      next_out.mem_rd        = in_data.mem_rd;
      next_out.mem_wr        = in_data.mem_wr;
      next_out.dest.gpr      = in_data.dest_gpr;
      // Segment loads target the seg1 register
      next_out.dest.seg      = in_data.seg1;
      next_out.dest.ld_gpr   = in_data.ld_gpr;
      next_out.dest.ld_seg   = in_data.ld_seg;
      next_out.seg_limit_exc = seg_limit_exc;
   end

   // Hold on downstream stall, bubble when nothing is accepted
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_v    <= 1'b0;
         out_data <= '0;
      end else if (!me_stall) begin
         out_v <= accept;
         if (accept) begin
            out_data <= next_out;
         end
      end
   end

   // Latched destination seen by the hazard check
   assign ag_dest = out_v ? out_data.dest : '0;

   a_hold_on_stall : assert property (@(posedge clk) disable iff (!rst_n)
      (out_v && me_stall) |=> (out_v && $stable(out_data)));

   a_empty_after_reset : assert property (@(posedge clk)
      $rose(rst_n) |-> !out_v);

   // The write address mux in the datapath has no IDT leg
   a_no_idt_write : assert property (@(posedge clk) disable iff (!rst_n)
      in_v |-> (in_data.wr_sel != `AG_SEL_IDT));

endmodule

`default_nettype wire

// File: src/ag_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ag_stage (
   input  wire                clk,
   input  wire                rst_n,
   input  wire                in_v,
   input  wire ag_pkg::ag_in_t   in_data,
   input  wire ag_pkg::ag_rf_t   rf_data,
   input  wire ag_pkg::ag_dest_t ex_dest,
   input  wire ag_pkg::ag_dest_t me_dest,
   input  wire                me_stall,
   output logic               out_v,
   output ag_pkg::ag_out_t    out_data,
   output logic               stall
);

   ag_pkg::addr_t    mem_rd_addr;
   ag_pkg::addr_t    mem_wr_addr;
   ag_pkg::addr_t    sp_xchg_data;
   ag_pkg::addr_t    lim_offset;
   ag_pkg::addr_t    neip;
   ag_pkg::seg_sel_t ncs;
   ag_pkg::ag_dest_t ag_dest;
   logic             seg_limit_exc;
   logic             dep_stall;

   ag_addr_calc addr_calc_inst (
      .in_data      (in_data),
      .rf_data      (rf_data),
      .mem_rd_addr  (mem_rd_addr),
      .mem_wr_addr  (mem_wr_addr),
      .sp_xchg_data (sp_xchg_data),
      .lim_offset   (lim_offset)
   );

   ag_next_ip next_ip_inst (
      .in_data (in_data),
      .neip    (neip),
      .ncs     (ncs)
   );

   segment_limit_check seg_limit_inst (
      .in_v          (in_v),
      .in_data       (in_data),
      .lim_offset    (lim_offset),
      .seg_limit_exc (seg_limit_exc)
   );

   reg_dependency_check dep_check_inst (
      .in_v      (in_v),
      .in_data   (in_data),
      .ag_dest   (ag_dest),
      .ex_dest   (ex_dest),
      .me_dest   (me_dest),
      .dep_stall (dep_stall)
   );

   ag_control control_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .in_v          (in_v),
      .me_stall      (me_stall),
      .dep_stall     (dep_stall),
      .mem_rd_addr   (mem_rd_addr),
      .mem_wr_addr   (mem_wr_addr),
      .sp_xchg_data  (sp_xchg_data),
      .neip          (neip),
      .ncs           (ncs),
      .seg_limit_exc (seg_limit_exc),
      .in_data       (in_data),
      .out_v         (out_v),
      .out_data      (out_data),
      .ag_dest       (ag_dest),
      .stall         (stall)
   );

endmodule

`default_nettype wire

// File: test/ag_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "ag_defines.svh"

module ag_checker (
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire                    in_v,
   input  wire ag_pkg::ag_in_t    in_data,
   input  wire ag_pkg::ag_rf_t    rf_data,
   input  wire ag_pkg::ag_dest_t  ex_dest,
   input  wire ag_pkg::ag_dest_t  me_dest,
   input  wire                    me_stall,
   input  wire                    out_v,
   input  wire ag_pkg::ag_out_t   out_data,
   input  wire                    stall,
   output int                     error_count,
   output int                     done_count
);

   ag_pkg::ag_out_t  exp_q [$];
   ag_pkg::ag_out_t  exp_cur;
   ag_pkg::ag_out_t  pend_ref;
   ag_pkg::ag_dest_t model_dest;
   logic             pend_accept;
   logic             pend_me_stall;
   logic             model_v;
   logic             exp_stall;

   function automatic ag_pkg::addr_t limit_for(input ag_pkg::seg_idx_t idx);
      case (idx)
         3'd0: return `AG_SEG_LIMIT_0;
         3'd1: return `AG_SEG_LIMIT_1;
         3'd2: return `AG_SEG_LIMIT_2;
         3'd3: return `AG_SEG_LIMIT_3;
         3'd4: return `AG_SEG_LIMIT_4;
         3'd5: return `AG_SEG_LIMIT_5;
         3'd6: return `AG_SEG_LIMIT_6;
         default: return `AG_SEG_LIMIT_7;
      endcase
   endfunction

   function automatic int size_bytes(input ag_pkg::data_size_t sz);
      if (sz == 2'd0) return 1;
      if (sz == 2'd1) return 2;
      return 4;
   endfunction

   // Expected output record for one accepted instruction
   function automatic ag_pkg::ag_out_t ag_ref_model(input ag_pkg::ag_in_t ins,
                                                    input ag_pkg::ag_rf_t rf);
      ag_pkg::ag_out_t  r;
      ag_pkg::addr_t    offset;
      ag_pkg::addr_t    ea;
      ag_pkg::addr_t    new_sp;
      ag_pkg::addr_t    stack;
      ag_pkg::addr_t    idt;
      ag_pkg::seg_sel_t seg_val;
      logic [32:0]      last;
      logic             ea_access;
      r = '0;
      offset = 32'h0;
      if (ins.disp_en) offset = offset + ins.disp32;
      if (ins.base_en) offset = offset + rf.sr1_data;
      if (ins.sib_en) offset = offset + rf.sib_i_data * (32'd1 << ins.sib_scale);
      seg_val = ins.use_cs_seg ? ins.cs : rf.seg1_data;
      ea = offset + seg_val * 32'h0001_0000;
      new_sp = rf.sr2_data;
      if (ins.sp_push) begin
         new_sp = new_sp - ((ins.data_size == 2'd2) ? `AG_PUSH_DWORD : `AG_PUSH_WORD);
      end
      stack = new_sp + rf.seg2_data * 32'h0001_0000;
      idt = `AG_IDTR_BASE + ins.exc_code * (32'd1 << `AG_IDT_SHIFT);
      case (ins.rd_sel)
         2'd1: r.mem_rd_addr = stack;
         2'd2: r.mem_rd_addr = idt;
         default: r.mem_rd_addr = ea;
      endcase
      r.mem_wr_addr = (ins.wr_sel == 2'd1) ? stack : ea;
      r.sp_xchg_data = ins.cmpxchg ? rf.sr3_data : new_sp;
      if (ins.jmp_abs) begin
         r.neip = ins.imm32;
         r.ncs  = ins.disp32[15:0];
      end else begin
         r.neip = ins.jmp_rel ? ins.eip + ins.disp32 : ins.eip;
         r.ncs  = ins.cs;
      end
      r.mem_rd = ins.mem_rd;
      r.mem_wr = ins.mem_wr;
      r.dest.gpr    = ins.dest_gpr;
      r.dest.seg    = ins.seg1;
      r.dest.ld_gpr = ins.ld_gpr;
      r.dest.ld_seg = ins.ld_seg;
      ea_access = (ins.mem_rd && ins.rd_sel == 2'd0) || (ins.mem_wr && ins.wr_sel == 2'd0);
      last = {1'b0, offset} + size_bytes(ins.data_size) - 1;
      r.seg_limit_exc = ea_access && (last > {1'b0, limit_for(ins.seg1)});
      return r;
   endfunction

   function automatic logic src_blocked(input ag_pkg::ag_in_t ins,
                                        input ag_pkg::ag_dest_t d);
      logic hit;
      hit = 1'b0;
      if (d.ld_gpr) begin
         hit = hit | (ins.sr1_needed && ins.sr1 == d.gpr);
         hit = hit | (ins.sr2_needed && ins.sr2 == d.gpr);
         hit = hit | (ins.sib_en && ins.sib_i == d.gpr);
         hit = hit | (ins.cmpxchg && ins.sr3 == d.gpr);
      end
      if (d.ld_seg) begin
         hit = hit | (ins.seg1_needed && ins.seg1 == d.seg);
         hit = hit | (ins.seg2_needed && ins.seg2 == d.seg);
      end
      return hit;
   endfunction

   task automatic compare_field(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      if (got !== exp) begin
         $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
         error_count++;
      end
   endtask

   task automatic compare_record(input ag_pkg::ag_out_t got, input ag_pkg::ag_out_t exp);
      compare_field("neip", got.neip, exp.neip);
      compare_field("ncs", 32'(got.ncs), 32'(exp.ncs));
      compare_field("mem_rd_addr", got.mem_rd_addr, exp.mem_rd_addr);
      compare_field("mem_wr_addr", got.mem_wr_addr, exp.mem_wr_addr);
      compare_field("sp_xchg_data", got.sp_xchg_data, exp.sp_xchg_data);
      compare_field("mem_rd", 32'(got.mem_rd), 32'(exp.mem_rd));
      compare_field("mem_wr", 32'(got.mem_wr), 32'(exp.mem_wr));
      compare_field("dest", 32'(got.dest), 32'(exp.dest));
      compare_field("seg_limit_exc", 32'(got.seg_limit_exc), 32'(exp.seg_limit_exc));
   endtask

   initial begin
      error_count = 0;
      done_count  = 0;
   end

   // Outputs are sampled mid-cycle; the pending decision stands for the rising edge before
   always @(negedge clk) begin
      if (rst_n !== 1'b1) begin
         exp_q.delete();
         exp_cur       = '0;
         model_v       = 1'b0;
         pend_accept   = 1'b0;
         pend_me_stall = 1'b0;
      end else begin
         if (pend_accept) begin
            exp_q.push_back(pend_ref);
         end
         if (!pend_me_stall) begin
            model_v = pend_accept;
         end
         compare_field("out_v", 32'(out_v), 32'(model_v));
         if (!pend_me_stall && out_v) begin
            if (exp_q.size() == 0) begin
               $display("out_v went high with no instruction outstanding at %0t", $time);
               error_count++;
            end else begin
               exp_cur = exp_q.pop_front();
               compare_record(out_data, exp_cur);
               done_count++;
            end
         end else if (pend_me_stall && model_v && out_v) begin
            compare_record(out_data, exp_cur);
         end
         model_dest = model_v ? exp_cur.dest : '0;
         exp_stall = me_stall | (in_v & (src_blocked(in_data, model_dest) |
                                         src_blocked(in_data, ex_dest) |
                                         src_blocked(in_data, me_dest)));
         compare_field("stall", 32'(stall), 32'(exp_stall));
         pend_accept   = in_v && !exp_stall;
         pend_me_stall = me_stall;
         pend_ref      = ag_ref_model(in_data, rf_data);
      end
   end

endmodule

`default_nettype wire

// File: test/tb_ag_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ag_stage;

   localparam int NUM_INSTR       = 400;
   localparam int CLK_PERIOD      = 10;
   localparam int WATCHDOG_CYCLES = NUM_INSTR * 4 + 200;

   logic             clk;
   logic             rst_n;
   logic             in_v;
   ag_pkg::ag_in_t   in_data;
   ag_pkg::ag_rf_t   rf_data;
   ag_pkg::ag_dest_t ex_dest;
   ag_pkg::ag_dest_t me_dest;
   logic             me_stall;
   logic             out_v;
   ag_pkg::ag_out_t  out_data;
   logic             stall;
   int               error_count;
   int               done_count;
   integer           seed;
   int               accepted;
   logic             took;

   ag_stage ag_stage_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_v     (in_v),
      .in_data  (in_data),
      .rf_data  (rf_data),
      .ex_dest  (ex_dest),
      .me_dest  (me_dest),
      .me_stall (me_stall),
      .out_v    (out_v),
      .out_data (out_data),
      .stall    (stall)
   );

   ag_checker checker_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_v        (in_v),
      .in_data     (in_data),
      .rf_data     (rf_data),
      .ex_dest     (ex_dest),
      .me_dest     (me_dest),
      .me_stall    (me_stall),
      .out_v       (out_v),
      .out_data    (out_data),
      .stall       (stall),
      .error_count (error_count),
      .done_count  (done_count)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic ag_pkg::ag_dest_t make_dest(input int r);
      ag_pkg::ag_dest_t d;
      d.gpr    = r[2:0];
      d.seg    = r[5:3];
      d.ld_gpr = (r[7:6] == 2'b00);
      d.ld_seg = (r[9:8] == 2'b00);
      return d;
   endfunction

   task automatic new_instruction();
      logic [31:0] mask;
      int          kind;
      // Small offset ranges so that some accesses stay inside the limits
      case ($unsigned($random(seed)) % 4)
         0: mask = 32'h0000_0FFF;
         1: mask = 32'h0000_FFFF;
         2: mask = 32'h000F_FFFF;
         default: mask = 32'hFFFF_FFFF;
      endcase
      kind = $unsigned($random(seed)) % 4;
      in_data             = $random(seed) ^ {$random(seed), $random(seed),
                                             $random(seed), $random(seed),
                                             $random(seed), $random(seed)};
      in_data.disp32      = $random(seed) & mask;
      in_data.data_size   = $unsigned($random(seed)) % 3;
      in_data.cmpxchg     = ($random(seed) & 3) == 0;
      in_data.jmp_rel     = (kind == 2);
      in_data.jmp_abs     = (kind == 3);
      in_data.rd_sel      = $unsigned($random(seed)) % 3;
      in_data.wr_sel      = $unsigned($random(seed)) % 2;
      in_data.ld_gpr      = ($random(seed) & 3) == 0;
      in_data.ld_seg      = ($random(seed) & 7) == 0;
      rf_data.sr1_data    = $random(seed) & mask;
      rf_data.sr2_data    = $random(seed);
      rf_data.sr3_data    = $random(seed);
      rf_data.sib_i_data  = $random(seed) & mask;
      rf_data.seg1_data   = $random(seed);
      rf_data.seg2_data   = $random(seed);
   endtask

   task automatic random_env();
      ex_dest  = make_dest($random(seed));
      me_dest  = make_dest($random(seed));
      me_stall = ($unsigned($random(seed)) % 5) == 0;
   endtask

   initial begin
      seed     = 68262;
      rst_n    = 1'b0;
      in_v     = 1'b0;
      in_data  = '0;
      rf_data  = '0;
      ex_dest  = '0;
      me_dest  = '0;
      me_stall = 1'b0;
      accepted = 0;
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;
      new_instruction();
      while (accepted < NUM_INSTR) begin
         @(negedge clk);
         took = in_v && !stall;
         @(posedge clk);
         #1;
         random_env();
         if (took) begin
            accepted++;
            new_instruction();
            in_v = (accepted < NUM_INSTR) && (($random(seed) & 7) != 0);
         end else if (!in_v) begin
            in_v = ($random(seed) & 7) != 0;
         end
      end
      in_v     = 1'b0;
      me_stall = 1'b0;
      ex_dest  = '0;
      me_dest  = '0;
      wait (done_count == NUM_INSTR);
      repeat (3) @(negedge clk);
      $display("Checked %0d of %0d instructions, %0d errors",
               done_count, NUM_INSTR, error_count);
      if (error_count == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout after %0d cycles with %0d instructions checked",
               WATCHDOG_CYCLES, done_count);
      $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
+incdir+common
common/ag_pkg.sv
addr_calc/ag_addr_calc.sv
src/ag_next_ip.sv
src/segment_limit_check.sv
src/reg_dependency_check.sv
src/ag_control.sv
src/ag_stage.sv
test/ag_checker.sv
test/tb_ag_stage.sv
